//--- project.f
hdl/serdes_pkg.sv
hdl/word_serializer.sv
hdl/word_deserializer.sv
hdl/word_aligner.sv
hdl/serdes_test.sv
hdl/wb_regs.sv
hdl/serdes_top.sv
dv/tb_clock.sv
dv/serdes_props.sv
dv/serdes_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the SERDES loopback testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f project.f --top-module serdes_tb

status=0
./obj_dir/Vserdes_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
    echo "Simulator exited with status $status."
    exit 1
fi

if grep -qF "** FAIL **" sim.log; then
    exit 1
fi

if ! grep -qF "** PASS **" sim.log; then
    echo "No pass line in sim.log."
    exit 1
fi

exit 0

//--- dv/serdes_tb.sv
`timescale 1ns/10ps

module serdes_tb;

    localparam int DATA_WIDTH  = 6;
    localparam int CYCLE_LIMIT = 20000;   // Eight lock searches plus the error and relock tests.

    logic                 CLK;
    logic                 rst;
    serdes_pkg::wb_req_t  wb_req;
    serdes_pkg::wb_rsp_t  wb_rsp;
    logic                 ser_in;
    logic                 ser_out;
    logic                 ser_oe;

    integer               seed;
    int                   cycles;
    int                   errors;
    int                   checks;
    int                   tests;
    int                   req_count;
    int                   ack_count;
    int                   flips;
    int                   k;
    int                   errs_at_start;
    logic [2:0]           delay;
    logic                 flip_req;
    logic [7:0]           line;
    serdes_pkg::word_t    pat;
    serdes_pkg::word_t    pat2;
    serdes_pkg::wb_data_t rd;

    string                name_q[$];
    logic [15:0]          exp_q[$];
    logic [15:0]          got_q[$];

    tb_clock u_clk (.CLK(CLK));

    serdes_top #(
        .DATA_WIDTH (DATA_WIDTH)
    ) UUT (
        .CLK     (CLK),
        .rst     (rst),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .ser_in  (ser_in),
        .ser_out (ser_out),
        .ser_oe  (ser_oe)
    );

    // ------------------------------------------------------------
    // Reference model and pattern choice
    // ------------------------------------------------------------
    function automatic serdes_pkg::word_t mask_word(input serdes_pkg::word_t w);
        return w & serdes_pkg::word_t'((9'd1 << DATA_WIDTH) - 9'd1);
    endfunction

    // True when no rotation within the width gives the word back.
    function automatic bit is_aperiodic(input serdes_pkg::word_t w);
        serdes_pkg::word_t m;
        serdes_pkg::word_t r;
        m = mask_word(w);
        r = m;
        for (int i = 1; i < DATA_WIDTH; i++) begin
            r = mask_word({r[6:0], r[DATA_WIDTH-1]});
            if (r == m) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    function automatic serdes_pkg::word_t pick_pattern(input serdes_pkg::word_t upper);
        serdes_pkg::word_t w;
        w = '0;
        while (!is_aperiodic(w)) begin
            w = serdes_pkg::word_t'($random(seed)) | upper;
        end
        return w;
    endfunction

    // ------------------------------------------------------------
    // Line loopback, cycle limit, ack count, compare
    // ------------------------------------------------------------
    always @(posedge CLK) begin
        #1;
        line = {line[6:0], ser_out ^ flip_req};   // Optional single bit error.
        if (flip_req) begin
            flips++;
            flip_req = 1'b0;
        end
        ser_in = line[delay];
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not end within %0d cycles.", CYCLE_LIMIT);
            $display("** FAIL **");
            $finish;
        end
    end

    always @(negedge CLK) begin
        if (wb_rsp.ack) begin
            ack_count++;
        end
    end

    always @(negedge CLK) begin : compare
        string       name;
        logic [15:0] exp;
        logic [15:0] got;
        while (name_q.size() > 0) begin
            name = name_q.pop_front();
            exp  = exp_q.pop_front();
            got  = got_q.pop_front();
            checks++;
            if (got !== exp) begin
                $display("FAIL %s: expected %h, got %h", name, exp, got);
                errors++;
            end
        end
    end

    // ------------------------------------------------------------
    // Stimulus tasks
    // ------------------------------------------------------------
    task automatic post_check(input string name, input logic [15:0] exp,
                              input logic [15:0] got);
        name_q.push_back(name);
        exp_q.push_back(exp);
        got_q.push_back(got);
    endtask

    task automatic apply_reset();
        @(posedge CLK);
        #1;
        rst = 1'b1;
        repeat (5) @(posedge CLK);
        #1;
        rst = 1'b0;
    endtask

    task automatic set_delay(input int d);
        @(negedge CLK);
        delay = 3'(d);
    endtask

    task automatic inject_flip();
        @(negedge CLK);
        flip_req = 1'b1;
        @(negedge CLK);                           // Taken by the loopback.
    endtask

    task automatic wb_cycle(input serdes_pkg::reg_addr_t adr, input logic we,
                            input serdes_pkg::wb_data_t dat,
                            output serdes_pkg::wb_data_t rdat);
        int waited;
        waited = 0;
        @(posedge CLK);
        #1;
        wb_req = '{adr: adr, dat: dat, we: we, cyc: 1'b1, stb: 1'b1};
        req_count++;
        do begin
            @(posedge CLK);
            #1;
            waited++;
        end while (!wb_rsp.ack && waited < 8);
        rdat = wb_rsp.dat;
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
        if (waited >= 8 && !wb_rsp.ack) begin
            $display("Register %0d gave no ack within 8 cycles.", adr);
            errors++;
        end
        @(posedge CLK);
        #1;
        if (wb_rsp.ack) begin
            $display("Register %0d gave a second ack.", adr);
            errors++;
        end
    endtask

    task automatic reg_write(input serdes_pkg::reg_addr_t adr, input serdes_pkg::wb_data_t dat);
        serdes_pkg::wb_data_t unused;
        wb_cycle(adr, 1'b1, dat, unused);
    endtask

    task automatic reg_read(input serdes_pkg::reg_addr_t adr, output serdes_pkg::wb_data_t dat);
        wb_cycle(adr, 1'b0, '0, dat);
    endtask

    // Polls STATUS until the locked bit reaches the given level.
    task automatic wait_locked(input logic level, input string what);
        serdes_pkg::wb_data_t st;
        int polls;
        polls = 0;
        st = {15'h0000, ~level};
        while (st[0] !== level && polls < 200) begin
            reg_read(serdes_pkg::REG_STATUS, st);
            polls++;
        end
        if (st[0] !== level) begin
            $display("%s: locked bit did not become %0d within %0d reads.", what, level, polls);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        @(negedge CLK);
        #1;                                       // Compare queue drained.
        tests++;
        $display("%s: done, %0d errors", name, errors - errs_at_start);
        errs_at_start = errors;
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        seed          = 79119;
        rst           = 1'b1;
        wb_req        = '0;
        ser_in        = 1'b0;
        flip_req      = 1'b0;
        line          = '0;
        delay         = '0;
        cycles        = 0;
        errors        = 0;
        checks        = 0;
        tests         = 0;
        req_count     = 0;
        ack_count     = 0;
        flips         = 0;
        errs_at_start = 0;
        apply_reset();

        reg_read(serdes_pkg::REG_STATUS, rd);
        post_check("status after reset", 16'h0000, rd);
        reg_read(serdes_pkg::REG_ERR_COUNT, rd);
        post_check("err_count after reset", 16'h0000, rd);
        post_check("ser_oe after reset", 16'h0000, {15'h0000, ser_oe});
        finish_test("reset values");

        pat = serdes_pkg::word_t'($random(seed));
        reg_write(serdes_pkg::REG_PATTERN, {8'h00, pat});
        reg_read(serdes_pkg::REG_PATTERN, rd);
        post_check("pattern readback", {8'h00, pat}, rd);
        reg_write(serdes_pkg::REG_CONTROL, 16'h0001);
        reg_read(serdes_pkg::REG_CONTROL, rd);
        post_check("control readback", 16'h0001, rd);
        reg_write(serdes_pkg::REG_CONTROL, 16'h0000);
        for (int a = 5; a < 8; a++) begin
            reg_read(serdes_pkg::reg_addr_t'(a), rd);
            post_check($sformatf("unmapped read %0d", a), 16'h0000, rd);
        end
        post_check("ack count", 16'(req_count), 16'(ack_count));
        finish_test("register access");

        for (int d = 0; d < 8; d++) begin
            apply_reset();
            set_delay(d);
            pat = pick_pattern(8'h00);
            reg_write(serdes_pkg::REG_PATTERN, {8'h00, pat});
            reg_write(serdes_pkg::REG_CONTROL, 16'h0001);
            wait_locked(1'b1, $sformatf("lock at delay %0d", d));
            reg_read(serdes_pkg::REG_RX_WORD, rd);
            post_check($sformatf("rx_word at delay %0d", d), {8'h00, mask_word(pat)}, rd);
        end
        finish_test("lock at every delay");

        apply_reset();
        set_delay(3);
        pat = pick_pattern(8'hC0);                // Bits above the width set.
        reg_write(serdes_pkg::REG_PATTERN, {8'h00, pat});
        reg_write(serdes_pkg::REG_CONTROL, 16'h0001);
        post_check("ser_oe enabled", 16'h0001, {15'h0000, ser_oe});
        wait_locked(1'b1, "lock with masked pattern");
        reg_read(serdes_pkg::REG_RX_WORD, rd);
        post_check("rx_word masked", {8'h00, mask_word(pat)}, rd);
        finish_test("masking");

        reg_write(serdes_pkg::REG_ERR_COUNT, 16'h0000);
        flips = 0;
        k = 4 + ($random(seed) & 7);
        for (int i = 0; i < k; i++) begin
            repeat (12 + ($random(seed) & 7)) @(posedge CLK);   // At least two words apart.
            inject_flip();
        end
        repeat (30) @(posedge CLK);               // Line delay plus one word.
        reg_read(serdes_pkg::REG_ERR_COUNT, rd);
        post_check("err_count after flips", 16'(flips), rd);
        reg_read(serdes_pkg::REG_STATUS, rd);
        post_check("locked after flips", 16'h0001, {15'h0000, rd[0]});
        finish_test("error counting");

        reg_write(serdes_pkg::REG_ERR_COUNT, 16'h0000);
        reg_read(serdes_pkg::REG_ERR_COUNT, rd);
        post_check("err_count after clear", 16'h0000, rd);
        pat2 = pat;
        while (mask_word(pat2) == mask_word(pat)) begin
            pat2 = pick_pattern(8'h00);
        end
        reg_write(serdes_pkg::REG_PATTERN, {8'h00, pat2});
        set_delay(4);                             // New word arrives one bit later.
        wait_locked(1'b0, "lock drop");
        wait_locked(1'b1, "relock");
        reg_read(serdes_pkg::REG_RX_WORD, rd);
        post_check("rx_word after relock", {8'h00, mask_word(pat2)}, rd);
        reg_read(serdes_pkg::REG_STATUS, rd);     // Slips restart at the drop.
        post_check("status after relock", 16'h0101, rd);
        finish_test("clear and relock");

        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- dv/serdes_props.sv
`timescale 1ns/10ps

module serdes_props (
    input logic                CLK,
    input logic                rst,
    input serdes_pkg::wb_req_t wb_req,
    input serdes_pkg::wb_rsp_t wb_rsp,
    input logic                rx_valid,
    input logic                match,
    input logic                bitslip,
    input logic                locked
);

    logic req;

    assign req = wb_req.cyc & wb_req.stb;

    // ------------------------------------------------------------
    // Wishbone handshake
    // ------------------------------------------------------------
    ack_after_req: assert property (@(posedge CLK) disable iff (rst)
        req && !wb_rsp.ack |=> wb_rsp.ack)
        else $error("no ack one cycle after a request");

    ack_single: assert property (@(posedge CLK) disable iff (rst)
        wb_rsp.ack |=> !wb_rsp.ack)
        else $error("ack held for more than one cycle");

    ack_needs_req: assert property (@(posedge CLK) disable iff (rst)
        wb_rsp.ack |-> $past(req))
        else $error("ack without a request");

    // ------------------------------------------------------------
    // Alignment
    // ------------------------------------------------------------
    slip_pulse: assert property (@(posedge CLK) disable iff (rst)
        bitslip |=> !bitslip)
        else $error("bitslip wider than one cycle");

    slip_on_miss: assert property (@(posedge CLK) disable iff (rst)
        bitslip |-> $past(rx_valid && !match))
        else $error("bitslip without a mismatching word");

    lock_on_match: assert property (@(posedge CLK) disable iff (rst)
        $rose(locked) |-> $past(rx_valid && match))
        else $error("lock without a matching word");

endmodule

bind wb_regs serdes_props u_wb_props (
    .CLK      (CLK),
    .rst      (rst),
    .wb_req   (wb_req),
    .wb_rsp   (wb_rsp),
    .rx_valid (1'b0),
    .match    (1'b0),
    .bitslip  (1'b0),
    .locked   (1'b0)
);

bind word_aligner serdes_props u_align_props (
    .CLK      (CLK),
    .rst      (rst),
    .wb_req   ('0),
    .wb_rsp   ('0),
    .rx_valid (rx_valid),
    .match    (match),
    .bitslip  (bitslip),
    .locked   (locked)
);

//--- dv/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
    parameter real PERIOD_NS = 8.0
) (
    output logic CLK
);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD_NS / 2.0) CLK = ~CLK;    // Free running.
    end

endmodule

//--- hdl/serdes_top.sv
`timescale 1ns/10ps

module serdes_top #(
    parameter int DATA_WIDTH = 8
) (
    input  logic                CLK,
    input  logic                rst,

    input  serdes_pkg::wb_req_t wb_req,
    output serdes_pkg::wb_rsp_t wb_rsp,

    input  logic                ser_in,
    output logic                ser_out,
    output logic                ser_oe
);

    logic [3:0]               rst_sr;
    logic                     rst_link;
    serdes_pkg::link_ctrl_t   ctrl;
    serdes_pkg::link_status_t status;

    // ------------------------------------------------------------
    // Reset stretcher
    // ------------------------------------------------------------
    // Link comes out of reset four cycles after the register block.
    always_ff @(posedge CLK) begin
        if (rst) begin
            rst_sr <= 4'hF;
        end else begin
            rst_sr <= rst_sr >> 1;         // Walk the ones out.
        end
    end

    assign rst_link = rst_sr[0];

    // ------------------------------------------------------------
    // Register port and link
    // ------------------------------------------------------------
    wb_regs u_regs (
        .CLK    (CLK),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .ctrl   (ctrl),
        .status (status)
    );

    serdes_test #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_test (
        .CLK     (CLK),
        .rst     (rst_link),
        .ctrl    (ctrl),
        .status  (status),
        .ser_in  (ser_in),
        .ser_out (ser_out),
        .ser_oe  (ser_oe)
    );

endmodule

//--- hdl/wb_regs.sv
`timescale 1ns/10ps

module wb_regs (
    input  logic                     CLK,
    input  logic                     rst,

    input  serdes_pkg::wb_req_t      wb_req,
    output serdes_pkg::wb_rsp_t      wb_rsp,

    output serdes_pkg::link_ctrl_t   ctrl,
    input  serdes_pkg::link_status_t status
);

    logic                 req_valid;
    logic                 wr_en;
    serdes_pkg::wb_data_t rd_data;
    serdes_pkg::wb_data_t dat_q;
    logic                 ack_q;
    serdes_pkg::word_t    pattern_q;
    logic                 enable_q;
    logic                 err_clear_q;

    // A request held through its ack cycle is not taken twice.
    assign req_valid = wb_req.cyc & wb_req.stb & ~ack_q;
    assign wr_en     = req_valid & wb_req.we;

    // ------------------------------------------------------------
    // Read mux
    // ------------------------------------------------------------
    always_comb begin
        case (wb_req.adr)
            serdes_pkg::REG_PATTERN:   rd_data = {8'h00, pattern_q};
            serdes_pkg::REG_CONTROL:   rd_data = {15'h0000, enable_q};
            serdes_pkg::REG_RX_WORD:   rd_data = {8'h00, status.rx_word};
            serdes_pkg::REG_STATUS:    rd_data = {status.slips, 7'h00, status.locked};
            serdes_pkg::REG_ERR_COUNT: rd_data = status.err_cnt;
            default:                   rd_data = '0;    // Unmapped.
        endcase
    end

    // ------------------------------------------------------------
    // Writes and handshake
    // ------------------------------------------------------------
    always_ff @(posedge CLK) begin
        if (rst) begin
            ack_q       <= 1'b0;
            pattern_q   <= '0;
            enable_q    <= 1'b0;
            err_clear_q <= 1'b0;
        end else begin
            ack_q       <= req_valid;      // One cycle after the request.
            err_clear_q <= wr_en && (wb_req.adr == serdes_pkg::REG_ERR_COUNT);
            if (wr_en && wb_req.adr == serdes_pkg::REG_PATTERN) begin
                pattern_q <= wb_req.dat[7:0];
            end
            if (wr_en && wb_req.adr == serdes_pkg::REG_CONTROL) begin
                enable_q <= wb_req.dat[0];
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (req_valid) begin
            dat_q <= rd_data;              // Valid with ack.
        end
    end

    assign wb_rsp = '{dat: dat_q, ack: ack_q};

    assign ctrl = '{
        enable:    enable_q,
        pattern:   pattern_q,
        err_clear: err_clear_q
    };

endmodule

//--- hdl/serdes_test.sv
`timescale 1ns/10ps

module serdes_test #(
    parameter int DATA_WIDTH = 8
) (
    input  logic                     CLK,
    input  logic                     rst,

    input  serdes_pkg::link_ctrl_t   ctrl,
    output serdes_pkg::link_status_t status,

    input  logic                     ser_in,
    output logic                     ser_out,
    output logic                     ser_oe
);

    localparam serdes_pkg::word_t MASK = serdes_pkg::width_mask(DATA_WIDTH);
    localparam logic [2:0] STB_LAST = 3'(DATA_WIDTH - 1);

    logic [2:0]            stb_cnt;
    logic                  word_stb;
    serdes_pkg::word_t     pattern_m;
    logic                  ser_bit;
    logic                  bitslip;
    serdes_pkg::word_t     rx_word;
    logic                  rx_valid;
    logic                  align_valid;
    logic                  locked;
    serdes_pkg::slip_cnt_t slips;
    serdes_pkg::err_cnt_t  err_cnt;

    assign pattern_m = ctrl.pattern & MASK;

    // ------------------------------------------------------------
    // Word strobe
    // ------------------------------------------------------------
    // Stands in for the divided word clock.
    always_ff @(posedge CLK) begin
        if (rst) begin
            stb_cnt <= '0;
        end else if (stb_cnt == STB_LAST) begin
            stb_cnt <= '0;
        end else begin
            stb_cnt <= stb_cnt + 3'd1;
        end
    end

    assign word_stb = (stb_cnt == STB_LAST);

    // ------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------
    word_serializer #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_ser (
        .CLK      (CLK),
        .rst      (rst),
        .word_stb (word_stb),
        .word     (pattern_m),
        .ser_out  (ser_bit)
    );

    word_deserializer #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_des (
        .CLK      (CLK),
        .rst      (rst),
        .ser_in   (ser_in),
        .word_stb (word_stb),
        .bitslip  (bitslip),
        .rx_word  (rx_word),
        .rx_valid (rx_valid)
    );

    assign align_valid = rx_valid & ctrl.enable;   // No search while idle.

    word_aligner #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_align (
        .CLK       (CLK),
        .rst       (rst),
        .rx_word   (rx_word),
        .rx_valid  (align_valid),
        .expected  (pattern_m),
        .err_clear (ctrl.err_clear),
        .bitslip   (bitslip),
        .locked    (locked),
        .slips     (slips),
        .err_cnt   (err_cnt)
    );

    assign ser_oe  = ctrl.enable;
    assign ser_out = ser_bit & ctrl.enable;      // Line idles low.

    assign status = '{
        locked:  locked,
        slips:   slips,
        err_cnt: err_cnt,
        rx_word: rx_word
    };

endmodule

//--- hdl/word_aligner.sv
`timescale 1ns/10ps

module word_aligner #(
    parameter int DATA_WIDTH = 8
) (
    input  logic                  CLK,
    input  logic                  rst,
    input  serdes_pkg::word_t     rx_word,
    input  logic                  rx_valid,
    input  serdes_pkg::word_t     expected,
    input  logic                  err_clear,
    output logic                  bitslip,
    output logic                  locked,
    output serdes_pkg::slip_cnt_t slips,
    output serdes_pkg::err_cnt_t  err_cnt
);

    localparam serdes_pkg::word_t MASK = serdes_pkg::width_mask(DATA_WIDTH);
    localparam int SETTLE_WORDS = 2;   // Words ignored after a slip.
    localparam int MISS_LIMIT   = 4;   // Mismatches in a row that drop lock.

    serdes_pkg::align_state_t state;
    logic [1:0]               settle_cnt;
    logic [1:0]               miss_run;
    logic                     match;

    assign match  = (rx_word & MASK) == (expected & MASK);
    assign locked = (state == serdes_pkg::LOCKED);

    // ------------------------------------------------------------
    // Alignment FSM
    // ------------------------------------------------------------
    always_ff @(posedge CLK) begin
        if (rst) begin
            state      <= serdes_pkg::SEARCH;
            bitslip    <= 1'b0;
            slips      <= '0;
            settle_cnt <= '0;
            miss_run   <= '0;
        end else begin
            bitslip <= 1'b0;
            if (rx_valid) begin
                case (state)
                    serdes_pkg::SEARCH: begin
                        if (match) begin
                            state    <= serdes_pkg::LOCKED;
                            miss_run <= '0;
                        end else begin
                            bitslip    <= 1'b1;
                            settle_cnt <= '0;
                            state      <= serdes_pkg::SETTLE;
                            if (slips != '1) begin
                                slips <= slips + 8'd1;
                            end
                        end
                    end
                    serdes_pkg::SETTLE: begin
                        // The deserializer needs a word or two to show the slip.
                        if (settle_cnt == 2'(SETTLE_WORDS - 1)) begin
                            state <= serdes_pkg::SEARCH;
                        end else begin
                            settle_cnt <= settle_cnt + 2'd1;
                        end
                    end
                    serdes_pkg::LOCKED: begin
                        if (match) begin
                            miss_run <= '0;
                        end else if (miss_run == 2'(MISS_LIMIT - 1)) begin
                            state    <= serdes_pkg::SEARCH;   // Lost it.
                            slips    <= '0;
                            miss_run <= '0;
                        end else begin
                            miss_run <= miss_run + 2'd1;
                        end
                    end
                    default: state <= serdes_pkg::SEARCH;
                endcase
            end
        end
    end

    // ------------------------------------------------------------
    // Error counter
    // ------------------------------------------------------------
    always_ff @(posedge CLK) begin
        if (rst) begin
            err_cnt <= '0;
        end else if (err_clear) begin
            err_cnt <= '0;
        end else if (rx_valid && locked && !match && err_cnt != '1) begin
            err_cnt <= err_cnt + 16'd1;    // Saturates.
        end
    end

endmodule

//--- hdl/word_deserializer.sv
`timescale 1ns/10ps

module word_deserializer #(
    parameter int DATA_WIDTH = 8
) (
    input  logic              CLK,
    input  logic              rst,
    input  logic              ser_in,
    input  logic              word_stb,
    input  logic              bitslip,
    output serdes_pkg::word_t rx_word,
    output logic              rx_valid
);

    localparam serdes_pkg::word_t MASK = serdes_pkg::width_mask(DATA_WIDTH);
    localparam logic [2:0] OFS_LAST = 3'(DATA_WIDTH - 1);

    serdes_pkg::word_t     shift_q;
    serdes_pkg::word_t     shift_nxt;
    logic [DATA_WIDTH-2:0] stb_dly;
    logic [DATA_WIDTH-1:0] stb_taps;
    logic [2:0]            slip_ofs;
    logic                  slip_pend;
    logic                  cap_stb;
    logic                  capture;

    // ------------------------------------------------------------
    // Input shift register
    // ------------------------------------------------------------
    // Newest bit enters at the LSB, so the oldest of the window
    // ends up at the MSB.
    assign shift_nxt = serdes_pkg::word_t'({shift_q, ser_in});

    always_ff @(posedge CLK) begin
        shift_q <= shift_nxt;
    end

    // ------------------------------------------------------------
    // Capture timing
    // ------------------------------------------------------------
    // Tap n of the strobe line is word_stb delayed by n cycles.
    assign stb_taps = {stb_dly, word_stb};
    assign cap_stb  = stb_taps[slip_ofs];
    assign capture  = cap_stb & ~slip_pend;

    always_ff @(posedge CLK) begin
        if (rst) begin
            stb_dly   <= '0;
            slip_ofs  <= '0;
            slip_pend <= 1'b0;
            rx_valid  <= 1'b0;
        end else begin
            stb_dly  <= stb_taps[DATA_WIDTH-2:0];
            rx_valid <= capture;
            if (cap_stb && slip_pend) begin
                // Skip this capture; the next tap fires one cycle later.
                slip_pend <= 1'b0;
                slip_ofs  <= (slip_ofs == OFS_LAST) ? 3'd0 : slip_ofs + 3'd1;
            end else if (bitslip) begin
                slip_pend <= 1'b1;         // Apply at the next capture.
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (capture) begin
            rx_word <= shift_nxt & MASK;
        end
    end

endmodule

//--- hdl/word_serializer.sv
`timescale 1ns/10ps

module word_serializer #(
    parameter int DATA_WIDTH = 8
) (
    input  logic              CLK,
    input  logic              rst,
    input  logic              word_stb,
    input  serdes_pkg::word_t word,
    output logic              ser_out
);

    serdes_pkg::word_t shift_q;

    // ------------------------------------------------------------
    // Parallel load, serial shift
    // ------------------------------------------------------------
    // The strobe comes every DATA_WIDTH cycles, so the register
    // shifts DATA_WIDTH-1 times between loads and the stream has
    // no gaps.
    always_ff @(posedge CLK) begin
        if (rst) begin
            shift_q <= '0;
        end else if (word_stb) begin
            shift_q <= word;               // New word next cycle.
        end else begin
            shift_q <= shift_q << 1;       // Next bit up to the top.
        end
    end

    // Top bit for the configured width, MSB first.
    assign ser_out = shift_q[DATA_WIDTH-1];

endmodule

//--- hdl/serdes_pkg.sv
package serdes_pkg;

    // ------------------------------------------------------------
    // Data widths
    // ------------------------------------------------------------
    typedef logic [7:0]  word_t;        // Parallel test word, upper bits unused.
    typedef logic [15:0] err_cnt_t;     // Saturating word error count.
    typedef logic [7:0]  slip_cnt_t;    // Bitslips since the last search.
    typedef logic [15:0] wb_data_t;     // Wishbone data.
    typedef logic [2:0]  reg_addr_t;    // Register index.

    // ------------------------------------------------------------
    // Register map
    // ------------------------------------------------------------
    localparam reg_addr_t REG_PATTERN   = 3'd0;
    localparam reg_addr_t REG_CONTROL   = 3'd1;    // Bit 0 is enable.
    localparam reg_addr_t REG_RX_WORD   = 3'd2;
    localparam reg_addr_t REG_STATUS    = 3'd3;    // Locked at 0, slips at 15:8.
    localparam reg_addr_t REG_ERR_COUNT = 3'd4;    // Write clears.

    // ------------------------------------------------------------
    // Buses
    // ------------------------------------------------------------
    typedef struct packed {
        reg_addr_t adr;
        wb_data_t  dat;
        logic      we;
        logic      cyc;
        logic      stb;
    } wb_req_t;

    typedef struct packed {
        wb_data_t dat;
        logic     ack;
    } wb_rsp_t;

    typedef struct packed {
        logic  enable;
        word_t pattern;
        logic  err_clear;                // One cycle pulse.
    } link_ctrl_t;

    typedef struct packed {
        logic      locked;
        slip_cnt_t slips;
        err_cnt_t  err_cnt;
        word_t     rx_word;
    } link_status_t;

    typedef enum logic [1:0] {
        SEARCH,
        SETTLE,
        LOCKED
    } align_state_t;

    // Ones in the low width bits of a word.
    function automatic word_t width_mask(input int unsigned width);
        word_t m;
        m = '0;
        for (int i = 0; i < $bits(word_t); i++) begin
            if (i < width) begin
                m[i] = 1'b1;
            end
        end
        return m;
    endfunction

endpackage
